//--- core_pkg.sv
package core_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned XLEN   = 32;
  localparam int unsigned NR_GPR = 32;

  // ------------------------------
  // RV32I encodings
  // ------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  // funct3 values shared by register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 for register ops, ALT selects SUB
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // ADDI x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [XLEN-1:0]           xlen_t;
  typedef logic [31:0]               instr_t;
  typedef logic [$clog2(NR_GPR)-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_ACK,
    FETCH_FULL
  } fetch_state_e;

endpackage

//--- gpr_regfile.sv
`timescale 1ns/1ps

module gpr_regfile (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  core_pkg::reg_addr_t  raddr_a_i,
  input  core_pkg::reg_addr_t  raddr_b_i,
  output core_pkg::xlen_t      rdata_a_o,
  output core_pkg::xlen_t      rdata_b_o,
  input  logic                 we_i,
  input  core_pkg::reg_addr_t  waddr_i,
  input  core_pkg::xlen_t      wdata_i
);
  import core_pkg::*;

  xlen_t regs_q [NR_GPR];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_GPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is hard zero, a same-cycle write is passed straight through
  assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                     (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                     (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs_q[raddr_b_i];

endmodule

//--- frontend.sv
`timescale 1ns/1ps

module frontend (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_pkg::xlen_t   boot_addr_i,
  // Wishbone classic master, reads only
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output core_pkg::xlen_t   wb_adr_o,
  input  core_pkg::instr_t  wb_dat_i,
  input  logic              wb_ack_i,
  // To decode
  output logic              fetch_valid_o,
  input  logic              fetch_ready_i,
  output core_pkg::xlen_t   fetch_pc_o,
  output core_pkg::instr_t  fetch_instr_o
);
  import core_pkg::*;

  fetch_state_e state_q, state_d;
  xlen_t        pc_q;
  xlen_t        buf_pc_q;
  instr_t       buf_instr_q;
  logic         bus_done;

  assign bus_done = (state_q == FETCH_WAIT_ACK) && wb_ack_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE:     state_d = FETCH_WAIT_ACK;
      FETCH_WAIT_ACK: if (wb_ack_i) state_d = FETCH_FULL;
      FETCH_FULL:     if (fetch_ready_i) state_d = FETCH_IDLE;
      default:        state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_IDLE;
      pc_q    <= boot_addr_i;
    end else begin
      state_q <= state_d;
      if (bus_done) begin
        pc_q <= pc_q + xlen_t'(4);
      end
    end
  end

  // Fetch buffer, one word
  always_ff @(posedge clk_i) begin
    if (bus_done) begin
      buf_pc_q    <= pc_q;
      buf_instr_q <= wb_dat_i;
    end
  end

  // Request held steady for the whole wait state
  assign wb_cyc_o = (state_q == FETCH_WAIT_ACK);
  assign wb_stb_o = (state_q == FETCH_WAIT_ACK);
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = pc_q;

  assign fetch_valid_o = (state_q == FETCH_FULL);
  assign fetch_pc_o    = buf_pc_q;
  assign fetch_instr_o = buf_instr_q;

  // ------------------------------
  // Bus protocol checks
  // ------------------------------
  stb_within_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> (wb_cyc_o && !$past(wb_ack_i)))
    else $error("wb_stb_o high outside a bus cycle or straight after ack");

  adr_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)))
    else $error("wb request changed before ack");

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From fetch
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  core_pkg::xlen_t      fetch_pc_i,
  input  core_pkg::instr_t     fetch_instr_i,
  // Instruction held in execute
  input  logic                 ex_busy_i,
  input  core_pkg::reg_addr_t  ex_rd_i,
  // Write-back from commit
  input  logic                 wb_we_i,
  input  core_pkg::reg_addr_t  wb_waddr_i,
  input  core_pkg::xlen_t      wb_wdata_i,
  // To execute
  output logic                 issue_valid_o,
  output core_pkg::xlen_t      issue_pc_o,
  output core_pkg::alu_op_e    issue_alu_op_o,
  output core_pkg::xlen_t      issue_op_a_o,
  output core_pkg::xlen_t      issue_op_b_o,
  output core_pkg::reg_addr_t  issue_rd_o,
  output logic                 issue_we_o,
  output logic                 issue_illegal_o
);
  import core_pkg::*;

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      imm_i;
  xlen_t      imm_u;
  alu_op_e    alu_op;
  xlen_t      op_a;
  xlen_t      op_b;
  logic       we;
  logic       illegal;
  logic       hazard_ex;
  logic       hazard_issue;
  logic       issue_fire;

  // Idle decode sees a NOP so no source register is named
  assign instr  = fetch_valid_i ? fetch_instr_i : INSTR_NOP;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};

  gpr_regfile u_regfile (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .raddr_a_i ( rs1        ),
    .raddr_b_i ( rs2        ),
    .rdata_a_o ( rs1_data   ),
    .rdata_b_o ( rs2_data   ),
    .we_i      ( wb_we_i    ),
    .waddr_i   ( wb_waddr_i ),
    .wdata_i   ( wb_wdata_i )
  );

  // ------------------------------
  // Decoder
  // ------------------------------
  always_comb begin
    alu_op  = ALU_ADD;
    op_a    = rs1_data;
    op_b    = rs2_data;
    we      = 1'b1;
    illegal = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        case ({funct7, funct3})
          {FUNCT7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
          {FUNCT7_ALT,  F3_ADD_SUB}: alu_op = ALU_SUB;
          {FUNCT7_BASE, F3_SLT}:     alu_op = ALU_SLT;
          {FUNCT7_BASE, F3_XOR}:     alu_op = ALU_XOR;
          {FUNCT7_BASE, F3_OR}:      alu_op = ALU_OR;
          {FUNCT7_BASE, F3_AND}:     alu_op = ALU_AND;
          default:                   illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        op_b = imm_i;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
      end
      OPCODE_LUI: begin
        alu_op = ALU_PASS_B;
        op_a   = '0;
        op_b   = imm_u;
      end
      default: illegal = 1'b1;
    endcase
    // Trap value travels in op_b
    if (illegal) begin
      alu_op = ALU_PASS_B;
      op_a   = '0;
      op_b   = instr;
      we     = 1'b0;
    end
  end

  // ------------------------------
  // Data hazards
  // ------------------------------
  assign hazard_ex = ex_busy_i && (ex_rd_i != '0) &&
                     ((ex_rd_i == rs1) || (ex_rd_i == rs2));

  // Producer still in the issue register, one cycle before execute
  assign hazard_issue = issue_valid_o && issue_we_o && (issue_rd_o != '0) &&
                        ((issue_rd_o == rs1) || (issue_rd_o == rs2));

  assign fetch_ready_o = !(hazard_ex || hazard_issue);
  assign issue_fire    = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= issue_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      issue_pc_o      <= fetch_pc_i;
      issue_alu_op_o  <= alu_op;
      issue_op_a_o    <= op_a;
      issue_op_b_o    <= op_b;
      issue_rd_o      <= rd;
      issue_we_o      <= we;
      issue_illegal_o <= illegal;
    end
  end

  // Older instruction now in execute never writes a source of the issued one
  no_issue_on_busy_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o |-> !(ex_busy_i && (ex_rd_i != '0) &&
                        ((ex_rd_i == $past(rs1)) || (ex_rd_i == $past(rs2)))))
    else $error("instruction issued against a busy ex_rd");

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From decode
  input  logic                 issue_valid_i,
  input  core_pkg::xlen_t      issue_pc_i,
  input  core_pkg::alu_op_e    issue_alu_op_i,
  input  core_pkg::xlen_t      issue_op_a_i,
  input  core_pkg::xlen_t      issue_op_b_i,
  input  core_pkg::reg_addr_t  issue_rd_i,
  input  logic                 issue_we_i,
  input  logic                 issue_illegal_i,
  // Hazard view back to decode
  output logic                 ex_busy_o,
  output core_pkg::reg_addr_t  ex_rd_o,
  // To commit
  output logic                 ex_valid_o,
  output core_pkg::xlen_t      ex_pc_o,
  output logic                 ex_we_o,
  output logic                 ex_illegal_o,
  output core_pkg::xlen_t      ex_result_o
);
  import core_pkg::*;

  xlen_t alu_res;

  // Illegal encodings arrive as PASS_B with the instruction word in op_b
  always_comb begin
    case (issue_alu_op_i)
      ALU_ADD:    alu_res = issue_op_a_i + issue_op_b_i;
      ALU_SUB:    alu_res = issue_op_a_i - issue_op_b_i;
      ALU_AND:    alu_res = issue_op_a_i & issue_op_b_i;
      ALU_OR:     alu_res = issue_op_a_i | issue_op_b_i;
      ALU_XOR:    alu_res = issue_op_a_i ^ issue_op_b_i;
      ALU_SLT:    alu_res = xlen_t'($signed(issue_op_a_i) < $signed(issue_op_b_i));
      ALU_PASS_B: alu_res = issue_op_b_i;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      ex_pc_o      <= issue_pc_i;
      ex_rd_o      <= issue_rd_i;
      ex_we_o      <= issue_we_i;
      ex_illegal_o <= issue_illegal_i;
      ex_result_o  <= alu_res;
    end
  end

  assign ex_busy_o = ex_valid_o && ex_we_o;

endmodule

//--- commit_stage.sv
`timescale 1ns/1ps

module commit_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From execute
  input  logic                 ex_valid_i,
  input  core_pkg::xlen_t      ex_pc_i,
  input  core_pkg::reg_addr_t  ex_rd_i,
  input  logic                 ex_we_i,
  input  logic                 ex_illegal_i,
  input  core_pkg::xlen_t      ex_result_i,
  // Register file write port
  output logic                 rf_we_o,
  output core_pkg::reg_addr_t  rf_waddr_o,
  output core_pkg::xlen_t      rf_wdata_o,
  // Commit port
  output logic                 commit_valid_o,
  output core_pkg::xlen_t      commit_pc_o,
  output core_pkg::reg_addr_t  commit_rd_o,
  output core_pkg::xlen_t      commit_wdata_o,
  output logic                 commit_illegal_o
);
  import core_pkg::*;

  logic commit_we_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      commit_pc_o      <= ex_pc_i;
      commit_rd_o      <= ex_rd_i;
      commit_we_q      <= ex_we_i;
      commit_illegal_o <= ex_illegal_i;
      commit_wdata_o   <= ex_result_i;
    end
  end

  // Exceptions reach here with we already cleared by decode
  assign rf_we_o    = commit_valid_o && commit_we_q;
  assign rf_waddr_o = commit_rd_o;
  assign rf_wdata_o = commit_wdata_o;

  rf_write_only_on_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_o |-> (commit_valid_o && !commit_illegal_o))
    else $error("register write without a legal retiring instruction");

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  core_pkg::xlen_t      boot_addr_i,
  // Instruction fetch bus
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic                 wb_we_o,
  output core_pkg::xlen_t      wb_adr_o,
  input  core_pkg::instr_t     wb_dat_i,
  input  logic                 wb_ack_i,
  // Retirement
  output logic                 commit_valid_o,
  output core_pkg::xlen_t      commit_pc_o,
  output core_pkg::reg_addr_t  commit_rd_o,
  output core_pkg::xlen_t      commit_wdata_o,
  output logic                 commit_illegal_o
);
  import core_pkg::*;

  // ------------------------------
  // Stage to stage wires
  // ------------------------------
  logic      fetch_valid;
  logic      fetch_ready;
  xlen_t     fetch_pc;
  instr_t    fetch_instr;

  logic      issue_valid;
  xlen_t     issue_pc;
  alu_op_e   issue_alu_op;
  xlen_t     issue_op_a;
  xlen_t     issue_op_b;
  reg_addr_t issue_rd;
  logic      issue_we;
  logic      issue_illegal;

  logic      ex_busy;
  reg_addr_t ex_rd;
  logic      ex_valid;
  xlen_t     ex_pc;
  logic      ex_we;
  logic      ex_illegal;
  xlen_t     ex_result;

  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  frontend u_frontend (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .boot_addr_i   ( boot_addr_i ),
    .wb_cyc_o      ( wb_cyc_o    ),
    .wb_stb_o      ( wb_stb_o    ),
    .wb_we_o       ( wb_we_o     ),
    .wb_adr_o      ( wb_adr_o    ),
    .wb_dat_i      ( wb_dat_i    ),
    .wb_ack_i      ( wb_ack_i    ),
    .fetch_valid_o ( fetch_valid ),
    .fetch_ready_i ( fetch_ready ),
    .fetch_pc_o    ( fetch_pc    ),
    .fetch_instr_o ( fetch_instr )
  );

  id_stage u_id_stage (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .fetch_valid_i   ( fetch_valid   ),
    .fetch_ready_o   ( fetch_ready   ),
    .fetch_pc_i      ( fetch_pc      ),
    .fetch_instr_i   ( fetch_instr   ),
    .ex_busy_i       ( ex_busy       ),
    .ex_rd_i         ( ex_rd         ),
    .wb_we_i         ( rf_we         ),
    .wb_waddr_i      ( rf_waddr      ),
    .wb_wdata_i      ( rf_wdata      ),
    .issue_valid_o   ( issue_valid   ),
    .issue_pc_o      ( issue_pc      ),
    .issue_alu_op_o  ( issue_alu_op  ),
    .issue_op_a_o    ( issue_op_a    ),
    .issue_op_b_o    ( issue_op_b    ),
    .issue_rd_o      ( issue_rd      ),
    .issue_we_o      ( issue_we      ),
    .issue_illegal_o ( issue_illegal )
  );

  ex_stage u_ex_stage (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .issue_valid_i   ( issue_valid   ),
    .issue_pc_i      ( issue_pc      ),
    .issue_alu_op_i  ( issue_alu_op  ),
    .issue_op_a_i    ( issue_op_a    ),
    .issue_op_b_i    ( issue_op_b    ),
    .issue_rd_i      ( issue_rd      ),
    .issue_we_i      ( issue_we      ),
    .issue_illegal_i ( issue_illegal ),
    .ex_busy_o       ( ex_busy       ),
    .ex_rd_o         ( ex_rd         ),
    .ex_valid_o      ( ex_valid      ),
    .ex_pc_o         ( ex_pc         ),
    .ex_we_o         ( ex_we         ),
    .ex_illegal_o    ( ex_illegal    ),
    .ex_result_o     ( ex_result     )
  );

  commit_stage u_commit_stage (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .ex_valid_i       ( ex_valid         ),
    .ex_pc_i          ( ex_pc            ),
    .ex_rd_i          ( ex_rd            ),
    .ex_we_i          ( ex_we            ),
    .ex_illegal_i     ( ex_illegal       ),
    .ex_result_i      ( ex_result        ),
    .rf_we_o          ( rf_we            ),
    .rf_waddr_o       ( rf_waddr         ),
    .rf_wdata_o       ( rf_wdata         ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

endmodule

//--- tb_core.sv
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  localparam xlen_t BOOT_ADDR      = 32'h0000_1000;
  localparam int    N_ROWS         = 21;
  localparam int    TIMEOUT_CYCLES = N_ROWS * 12 + 50;

  typedef logic [4:0] row_idx_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  xlen_t     boot_addr;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  xlen_t     wb_adr;
  instr_t    mem_dat;
  logic      mem_ack;
  logic      commit_valid_o;
  xlen_t     commit_pc_o;
  reg_addr_t commit_rd_o;
  xlen_t     commit_wdata_o;
  logic      commit_illegal_o;

  // Program and expected retirement, one row per instruction
  instr_t    prog_instr  [N_ROWS];
  reg_addr_t exp_rd      [N_ROWS];
  xlen_t     exp_wdata   [N_ROWS];
  logic      exp_illegal [N_ROWS];
  row_idx_t  n_loaded = '0;

  integer    seed = 32'hafcc121e;
  integer    wait_draw;
  logic      mem_busy;
  logic [1:0] wait_left;
  int        cycle_cnt = 0;
  int        rows_checked = 0;

  always #5 clk_i = ~clk_i;

  core_top u_dut (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .boot_addr_i      ( boot_addr        ),
    .wb_cyc_o         ( wb_cyc           ),
    .wb_stb_o         ( wb_stb           ),
    .wb_we_o          ( wb_we            ),
    .wb_adr_o         ( wb_adr           ),
    .wb_dat_i         ( mem_dat          ),
    .wb_ack_i         ( mem_ack          ),
    .commit_valid_o   ( commit_valid_o   ),
    .commit_pc_o      ( commit_pc_o      ),
    .commit_rd_o      ( commit_rd_o      ),
    .commit_wdata_o   ( commit_wdata_o   ),
    .commit_illegal_o ( commit_illegal_o )
  );

  // ------------------------------
  // Encoders and table setup
  // ------------------------------
  function automatic instr_t r_type(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic instr_t i_type(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
    return {imm, rs1, f3, rd, OPCODE_OP_IMM};
  endfunction

  function automatic instr_t u_type(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, OPCODE_LUI};
  endfunction

  task automatic append_row(input instr_t instr, input reg_addr_t rd, input xlen_t wdata,
                            input logic illegal);
    prog_instr[n_loaded]  = instr;
    exp_rd[n_loaded]      = rd;
    exp_wdata[n_loaded]   = wdata;
    exp_illegal[n_loaded] = illegal;
    n_loaded = n_loaded + 5'd1;
  endtask

  task automatic load_program;
    instr_t mul_word;
    mul_word = r_type(7'b0000001, 3'b000, 5'd1, 5'd1, 5'd2);
    append_row(i_type(3'b000, 5'd1, 5'd0, 12'h005), 5'd1, 32'h0000_0005, 1'b0);
    // Negative immediate
    append_row(i_type(3'b000, 5'd2, 5'd0, 12'hFFC), 5'd2, 32'hFFFF_FFFC, 1'b0);
    append_row(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0001, 1'b0);
    append_row(r_type(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'h0000_0009, 1'b0);
    append_row(r_type(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd2), 5'd5, 32'h0000_0004, 1'b0);
    append_row(r_type(7'b0000000, 3'b110, 5'd6, 5'd1, 5'd2), 5'd6, 32'hFFFF_FFFD, 1'b0);
    append_row(r_type(7'b0000000, 3'b100, 5'd7, 5'd1, 5'd2), 5'd7, 32'hFFFF_FFF9, 1'b0);
    // SLT both ways round a negative operand
    append_row(r_type(7'b0000000, 3'b010, 5'd8, 5'd2, 5'd1), 5'd8, 32'h0000_0001, 1'b0);
    append_row(r_type(7'b0000000, 3'b010, 5'd9, 5'd1, 5'd2), 5'd9, 32'h0000_0000, 1'b0);
    append_row(i_type(3'b111, 5'd10, 5'd2, 12'h0FF), 5'd10, 32'h0000_00FC, 1'b0);
    append_row(i_type(3'b110, 5'd11, 5'd1, 12'h0F0), 5'd11, 32'h0000_00F5, 1'b0);
    append_row(i_type(3'b100, 5'd12, 5'd1, 12'hFFF), 5'd12, 32'hFFFF_FFFA, 1'b0);
    append_row(u_type(5'd13, 20'h12345), 5'd13, 32'h1234_5000, 1'b0);
    // Dependent chain through x13, x14 and x15
    append_row(i_type(3'b000, 5'd13, 5'd13, 12'h678), 5'd13, 32'h1234_5678, 1'b0);
    append_row(r_type(7'b0000000, 3'b000, 5'd14, 5'd13, 5'd13), 5'd14, 32'h2468_ACF0, 1'b0);
    append_row(r_type(7'b0100000, 3'b000, 5'd15, 5'd14, 5'd13), 5'd15, 32'h1234_5678, 1'b0);
    // MUL and an unknown opcode, both naming x1
    append_row(mul_word, 5'd1, mul_word, 1'b1);
    append_row(32'h0000_00FF, 5'd1, 32'h0000_00FF, 1'b1);
    append_row(r_type(7'b0000000, 3'b000, 5'd16, 5'd1, 5'd0), 5'd16, 32'h0000_0005, 1'b0);
    // Write to x0 then read it back
    append_row(i_type(3'b000, 5'd0, 5'd1, 12'h007), 5'd0, 32'h0000_000C, 1'b0);
    append_row(r_type(7'b0000000, 3'b000, 5'd17, 5'd0, 5'd1), 5'd17, 32'h0000_0005, 1'b0);
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_xlen(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t actual,
                                input reg_addr_t expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s: got %b, expected %b", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ------------------------------
  // Wishbone memory model
  // ------------------------------
  function automatic instr_t mem_word(xlen_t adr);
    xlen_t       offset;
    logic [29:0] word_idx;
    offset   = adr - BOOT_ADDR;
    word_idx = offset[31:2];
    if (adr >= BOOT_ADDR && word_idx < 30'(N_ROWS)) begin
      return prog_instr[word_idx[4:0]];
    end
    return INSTR_NOP;
  endfunction

  // Ack after 0 to 3 extra wait cycles
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_ack   <= 1'b0;
      mem_busy  <= 1'b0;
      wait_left <= 2'd0;
    end else begin
      mem_ack <= 1'b0;
      if (wb_cyc && wb_stb && !mem_ack) begin
        if (!mem_busy) begin
          check_bit("wb_we_o", wb_we, 1'b0);
          wait_draw = $random(seed);
          if (wait_draw[1:0] == 2'd0) begin
            mem_ack <= 1'b1;
            mem_dat <= mem_word(wb_adr);
          end else begin
            mem_busy  <= 1'b1;
            wait_left <= wait_draw[1:0];
          end
        end else if (wait_left == 2'd1) begin
          mem_busy <= 1'b0;
          mem_ack  <= 1'b1;
          mem_dat  <= mem_word(wb_adr);
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d commits seen",
               cycle_cnt, rows_checked, N_ROWS);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic wait_commit;
    do begin
      @(negedge clk_i);
    end while (commit_valid_o !== 1'b1);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    row_idx_t row;
    rst_ni    = 1'b0;
    boot_addr = BOOT_ADDR;
    mem_ack   = 1'b0;
    mem_dat   = '0;
    mem_busy  = 1'b0;
    wait_left = 2'd0;
    load_program();

    repeat (3) @(posedge clk_i);
    // Outputs idle while in reset
    check_bit("wb_cyc_o", wb_cyc, 1'b0);
    check_bit("wb_stb_o", wb_stb, 1'b0);
    check_bit("commit_valid_o", commit_valid_o, 1'b0);
    rst_ni <= 1'b1;

    row = '0;
    repeat (N_ROWS) begin
      wait_commit();
      check_xlen("commit_pc_o", commit_pc_o, BOOT_ADDR + (xlen_t'(row) << 2));
      check_reg_addr("commit_rd_o", commit_rd_o, exp_rd[row]);
      check_xlen("commit_wdata_o", commit_wdata_o, exp_wdata[row]);
      check_bit("commit_illegal_o", commit_illegal_o, exp_illegal[row]);
      rows_checked = rows_checked + 1;
      row = row + 5'd1;
    end

    $display("test passed");
    $finish;
  end

endmodule

//--- src.f
core_pkg.sv
gpr_regfile.sv
frontend.sv
id_stage.sv
ex_stage.sv
commit_stage.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f src.f \
  --Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

out=$(./obj_dir/tb_core_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
